/* source/frogger_geom_pkg.sv */
`default_nettype none

package frogger_geom_pkg;

    // Playfield size in tiles
    localparam int GRID_W = 40;
    localparam int GRID_H = 30;

    // One tile coordinate, wide enough for either axis
    typedef logic [5:0] coord_t;

    // Last valid column and row
    localparam coord_t X_MAX = coord_t'(GRID_W - 1);
    localparam coord_t Y_MAX = coord_t'(GRID_H - 1);

    // Tile position, x in the upper half
    typedef struct packed {
        coord_t x;
        coord_t y;
    } pos_t;

    // Fixed travel direction of an object
    typedef enum logic {
        DIR_LEFT  = 1'b0,
        DIR_RIGHT = 1'b1
    } dir_t;

    // Car occupies a single tile
    typedef struct packed {
        pos_t pos;
        dir_t dir;
    } car_t;

    // Log x is its right end, body spans x-2 up to x
    typedef struct packed {
        pos_t pos;
        dir_t dir;
    } log_t;

    localparam int NUM_CARS = 5;
    localparam int NUM_LOGS = 3;

    // Leftmost entry is the highest index
    // One car per road row, 24 to 28, directions alternate
    localparam car_t [NUM_CARS-1:0] CAR_START = '{
        '{pos: '{x: 6'd35, y: 6'd28}, dir: DIR_RIGHT},
        '{pos: '{x: 6'd8,  y: 6'd27}, dir: DIR_LEFT},
        '{pos: '{x: 6'd15, y: 6'd26}, dir: DIR_RIGHT},
        '{pos: '{x: 6'd30, y: 6'd25}, dir: DIR_LEFT},
        '{pos: '{x: 6'd2,  y: 6'd24}, dir: DIR_RIGHT}
    };

    // Logs on river rows 10, 12 and 14
    localparam log_t [NUM_LOGS-1:0] LOG_START = '{
        '{pos: '{x: 6'd5,  y: 6'd14}, dir: DIR_RIGHT},
        '{pos: '{x: 6'd25, y: 6'd12}, dir: DIR_LEFT},
        '{pos: '{x: 6'd12, y: 6'd10}, dir: DIR_RIGHT}
    };

    // Frog start tile, bottom row centre
    localparam pos_t FROG_START = '{x: 6'd20, y: 6'd29};

endpackage

`default_nettype wire

/* source/frogger_game_pkg.sv */
`default_nettype none

package frogger_game_pkg;

    // Rows are given as tile coordinates
    import frogger_geom_pkg::*;

    // Player move request
    typedef enum logic [1:0] {
        MOVE_UP    = 2'd0,
        MOVE_DOWN  = 2'd1,
        MOVE_LEFT  = 2'd2,
        MOVE_RIGHT = 2'd3
    } move_t;

    // Lives counter, three at start
    typedef logic [1:0] lives_t;
    localparam lives_t LIVES_INIT = 2'd3;

    // Score counter, sticks at full scale
    typedef logic [7:0] score_t;
    localparam score_t SCORE_MAX = 8'd255;

    // River band, both ends inclusive
    localparam coord_t RIVER_TOP = 6'd10;
    localparam coord_t RIVER_BOT = 6'd14;

    // Reaching this row scores
    localparam coord_t GOAL_ROW = 6'd0;

    // Collision result for the current frog tile
    typedef struct packed {
        logic car_hit;
        logic on_log;
        logic in_water;
    } hit_t;

    // Game status seen from outside
    typedef struct packed {
        lives_t lives;
        score_t score;
        logic   game_over;
    } status_t;

endpackage

`default_nettype wire

/* source/frogger_obstacle_lane.sv */
`default_nettype none

module frogger_obstacle_lane
    import frogger_geom_pkg::*;
#(
    // Object type, needs pos and dir fields
    parameter type T_OBJ = car_t,
    // Objects in this lane group
    parameter int  N     = NUM_CARS
)
(
    input  wire               i_Clk,
    input  wire               i_arst_n,
    input  wire               i_step,
    input  wire T_OBJ [N-1:0] i_start,
    output T_OBJ [N-1:0]      o_objs
);

    // Positions after the next step
    T_OBJ [N-1:0] w_next;

    // Next column for one object
    // Leaving an edge puts it on the far column
    function automatic coord_t wrap_step(input coord_t x, input dir_t dir);
        coord_t nx;
        if (dir == DIR_RIGHT)
        begin
            nx = (x == X_MAX) ? '0 : x + 1'b1;
        end
        else
        begin
            nx = (x == '0) ? X_MAX : x - 1'b1;
        end
        return nx;
    endfunction

    // Only x moves, row and direction are fixed
    always_comb
    begin
        w_next = o_objs;
        for (int i = 0; i < N; i++)
        begin
            w_next[i].pos.x = wrap_step(o_objs[i].pos.x, o_objs[i].dir);
        end
    end

    // Start table on reset, one tile per step after that
    always_ff @(posedge i_Clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            o_objs <= i_start;
        end
        else if (i_step)
        begin
            o_objs <= w_next;
        end
    end

endmodule

`default_nettype wire

/* source/frogger_collisions.sv */
`default_nettype none

module frogger_collisions
    import frogger_geom_pkg::*;
    import frogger_game_pkg::*;
(
    input  wire                      i_Clk,
    input  wire                      i_arst_n,
    input  wire pos_t                i_frog,
    input  wire car_t [NUM_CARS-1:0] i_cars,
    input  wire log_t [NUM_LOGS-1:0] i_logs,
    output hit_t                     o_hit
);

    logic w_car_hit;
    logic w_on_log;
    logic w_river;

    // Log right end minus frog x, kept 6 bits so a frog right of the log wraps high
    coord_t [NUM_LOGS-1:0] w_log_dx;

    // Car hit when on the same row and one tile away or closer
    always_comb
    begin
        w_car_hit = 1'b0;
        for (int i = 0; i < NUM_CARS; i++)
        begin
            if ((i_cars[i].pos.y == i_frog.y) &&
                ((i_cars[i].pos.x == i_frog.x) ||
                 (i_cars[i].pos.x + 1'b1 == i_frog.x) ||
                 (i_frog.x + 1'b1 == i_cars[i].pos.x)))
            begin
                w_car_hit = 1'b1;
            end
        end
    end

    // Standing on a log covers its x and two tiles to the left
    always_comb
    begin
        w_on_log = 1'b0;
        for (int i = 0; i < NUM_LOGS; i++)
        begin
            w_log_dx[i] = i_logs[i].pos.x - i_frog.x;
            if ((i_logs[i].pos.y == i_frog.y) && (w_log_dx[i] <= coord_t'(2)))
            begin
                w_on_log = 1'b1;
            end
        end
    end

    // River band check
    assign w_river = (i_frog.y >= RIVER_TOP) && (i_frog.y <= RIVER_BOT);

    // One cycle behind the frog and object positions
    always_ff @(posedge i_Clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            o_hit <= '0;
        end
        else
        begin
            o_hit.car_hit  <= w_car_hit;
            o_hit.on_log   <= w_on_log;
            // A car hit takes priority over a fall
            o_hit.in_water <= w_river && !w_on_log && !w_car_hit;
        end
    end

endmodule

`default_nettype wire

/* source/frogger_frog_control.sv */
`default_nettype none

module frogger_frog_control
    import frogger_geom_pkg::*;
    import frogger_game_pkg::*;
(
    input  wire                      i_Clk,
    input  wire                      i_arst_n,
    input  wire                      i_move_valid,
    input  wire move_t               i_move,
    output logic                     o_move_ready,
    input  wire                      i_tick,
    input  wire hit_t                i_hit,
    input  wire log_t [NUM_LOGS-1:0] i_logs,
    output pos_t                     o_frog,
    output logic                     o_step,
    output status_t                  o_status
);

    // Settle phase, 0 when idle, 1 to 3 while an event works through
    logic [1:0] r_phase;
    // One tick held while busy
    logic       r_tick_pend;
    logic       w_idle;
    logic       w_move_fire;
    logic       w_lose_life;
    pos_t       r_frog;
    pos_t       w_move_frog;
    pos_t       w_carry_frog;
    status_t    r_status;

    // Game over freezes everything, ticks included
    assign w_idle       = (r_phase == 2'd0) && !r_status.game_over;
    // Tick wins over a move in the same idle cycle
    assign o_step       = w_idle && (i_tick || r_tick_pend);
    assign o_move_ready = w_idle && !i_tick && !r_tick_pend;
    assign w_move_fire  = i_move_valid && o_move_ready;
    assign w_lose_life  = i_hit.car_hit || i_hit.in_water;

    // Requested move, held at the grid edge
    always_comb
    begin
        w_move_frog = r_frog;
        case (i_move)
            MOVE_UP:    if (r_frog.y != '0)    w_move_frog.y = r_frog.y - 1'b1;
            MOVE_DOWN:  if (r_frog.y != Y_MAX) w_move_frog.y = r_frog.y + 1'b1;
            MOVE_LEFT:  if (r_frog.x != '0)    w_move_frog.x = r_frog.x - 1'b1;
            default:    if (r_frog.x != X_MAX) w_move_frog.x = r_frog.x + 1'b1;
        endcase
    end

    // Log carry on a step
    // One log per river row, so the row picks the log
    always_comb
    begin
        w_carry_frog = r_frog;
        for (int i = 0; i < NUM_LOGS; i++)
        begin
            if (i_hit.on_log && (i_logs[i].pos.y == r_frog.y))
            begin
                if (i_logs[i].dir == DIR_RIGHT)
                begin
                    if (r_frog.x != X_MAX)
                        w_carry_frog.x = r_frog.x + 1'b1;
                end
                else if (r_frog.x != '0)
                begin
                    w_carry_frog.x = r_frog.x - 1'b1;
                end
            end
        end
    end

    always_ff @(posedge i_Clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            r_phase     <= 2'd0;
            r_tick_pend <= 1'b0;
            r_frog      <= FROG_START;
            r_status    <= '{lives: LIVES_INIT, score: '0, game_over: 1'b0};
        end
        else
        begin
            // Extra ticks while one is held merge into it
            if (o_step)
                r_tick_pend <= 1'b0;
            else if (i_tick && !r_status.game_over)
                r_tick_pend <= 1'b1;

            // Cycle 0 of an event
            if (o_step || w_move_fire)
            begin
                r_phase <= 2'd1;
                r_frog  <= o_step ? w_carry_frog : w_move_frog;
            end
            else if (r_phase != 2'd0)
            begin
                // 3 wraps back to idle
                r_phase <= r_phase + 1'b1;
                // Hit result of the settled frog is on i_hit by now
                if (r_phase == 2'd3)
                begin
                    if (w_lose_life)
                    begin
                        r_frog         <= FROG_START;
                        r_status.lives <= r_status.lives - 1'b1;
                        if (r_status.lives == lives_t'(1))
                            r_status.game_over <= 1'b1;
                    end
                    else if (r_frog.y == GOAL_ROW)
                    begin
                        r_frog <= FROG_START;
                        if (r_status.score != SCORE_MAX)
                            r_status.score <= r_status.score + 1'b1;
                    end
                end
            end
        end
    end

    assign o_frog   = r_frog;
    assign o_status = r_status;

endmodule

`default_nettype wire

/* source/frogger_game.sv */
`default_nettype none

module frogger_game
    import frogger_geom_pkg::*;
    import frogger_game_pkg::*;
(
    input  wire                      i_Clk,
    input  wire                      i_arst_n,
    // Move request, valid/ready
    input  wire                      i_move_valid,
    input  wire move_t               i_move,
    output logic                     o_move_ready,
    // Frame tick, one cycle wide
    input  wire                      i_tick,
    // Game state
    output pos_t                     o_frog,
    output car_t [NUM_CARS-1:0]      o_cars,
    output log_t [NUM_LOGS-1:0]      o_logs,
    output status_t                  o_status
);

    pos_t                  w_frog;
    logic                  w_step;
    car_t [NUM_CARS-1:0]   w_cars;
    log_t [NUM_LOGS-1:0]   w_logs;
    hit_t                  w_hit;

    // Road lane
    frogger_obstacle_lane #(
        .T_OBJ (car_t),
        .N     (NUM_CARS)
    ) i_car_lane (
        .i_Clk    (i_Clk),
        .i_arst_n (i_arst_n),
        .i_step   (w_step),
        .i_start  (CAR_START),
        .o_objs   (w_cars)
    );

    // River lane
    frogger_obstacle_lane #(
        .T_OBJ (log_t),
        .N     (NUM_LOGS)
    ) i_log_lane (
        .i_Clk    (i_Clk),
        .i_arst_n (i_arst_n),
        .i_step   (w_step),
        .i_start  (LOG_START),
        .o_objs   (w_logs)
    );

    // Hit flags lag positions by a cycle
    frogger_collisions i_collisions (
        .i_Clk    (i_Clk),
        .i_arst_n (i_arst_n),
        .i_frog   (w_frog),
        .i_cars   (w_cars),
        .i_logs   (w_logs),
        .o_hit    (w_hit)
    );

    // Frog, tick latch and rules
    frogger_frog_control i_frog_control (
        .i_Clk        (i_Clk),
        .i_arst_n     (i_arst_n),
        .i_move_valid (i_move_valid),
        .i_move       (i_move),
        .o_move_ready (o_move_ready),
        .i_tick       (i_tick),
        .i_hit        (w_hit),
        .i_logs       (w_logs),
        .o_frog       (w_frog),
        .o_step       (w_step),
        .o_status     (o_status)
    );

    assign o_frog = w_frog;
    assign o_cars = w_cars;
    assign o_logs = w_logs;

endmodule

`default_nettype wire

/* verification/frogger_game_model.svh */
`ifndef FROGGER_GAME_MODEL_SVH
`define FROGGER_GAME_MODEL_SVH

// Reference game state, updated one whole event at a time
pos_t                m_frog;
car_t [NUM_CARS-1:0] m_cars;
log_t [NUM_LOGS-1:0] m_logs;
int                  m_lives;
int                  m_score;
logic                m_game_over;

// Expected status word
function automatic status_t model_status();
    status_t s;
    s.lives     = lives_t'(m_lives);
    s.score     = score_t'(m_score);
    s.game_over = m_game_over;
    return s;
endfunction

// Column held inside the grid
function automatic int clamp_col(input int x);
    if (x < 0)
        return 0;
    if (x > GRID_W - 1)
        return GRID_W - 1;
    return x;
endfunction

// Column wrapped to the far edge
function automatic int wrap_col(input int x);
    if (x < 0)
        return GRID_W - 1;
    if (x > GRID_W - 1)
        return 0;
    return x;
endfunction

function automatic int dir_delta(input dir_t d);
    return (d == DIR_RIGHT) ? 1 : -1;
endfunction

// Same row and at most one column apart
function automatic bit car_near(input pos_t f);
    int d;
    for (int i = 0; i < NUM_CARS; i++)
    begin
        d = int'(m_cars[i].pos.x) - int'(f.x);
        if ((m_cars[i].pos.y == f.y) && (d >= -1) && (d <= 1))
            return 1'b1;
    end
    return 1'b0;
endfunction

// Log body spans x-2 up to x, returns index or -1
function automatic int log_under(input pos_t f);
    int d;
    for (int i = 0; i < NUM_LOGS; i++)
    begin
        d = int'(m_logs[i].pos.x) - int'(f.x);
        if ((m_logs[i].pos.y == f.y) && (d >= 0) && (d <= 2))
            return i;
    end
    return -1;
endfunction

function automatic bit river_row(input coord_t y);
    return (int'(y) >= int'(RIVER_TOP)) && (int'(y) <= int'(RIVER_BOT));
endfunction

task automatic model_reset();
    m_frog      = FROG_START;
    m_cars      = CAR_START;
    m_logs      = LOG_START;
    m_lives     = int'(LIVES_INIT);
    m_score     = 0;
    m_game_over = 1'b0;
endtask

// Rules applied once frog and objects have settled
task automatic model_resolve();
    if (car_near(m_frog) || (river_row(m_frog.y) && (log_under(m_frog) < 0)))
    begin
        m_frog  = FROG_START;
        m_lives = m_lives - 1;
        if (m_lives == 0)
            m_game_over = 1'b1;
    end
    else if (m_frog.y == GOAL_ROW)
    begin
        m_frog = FROG_START;
        if (m_score < 255)
            m_score = m_score + 1;
    end
endtask

task automatic model_move(input move_t mv);
    int x;
    int y;
    if (m_game_over)
        return;
    x = int'(m_frog.x);
    y = int'(m_frog.y);
    case (mv)
        MOVE_UP:    y = (y > 0) ? y - 1 : y;
        MOVE_DOWN:  y = (y < GRID_H - 1) ? y + 1 : y;
        MOVE_LEFT:  x = clamp_col(x - 1);
        default:    x = clamp_col(x + 1);
    endcase
    m_frog.x = coord_t'(x);
    m_frog.y = coord_t'(y);
    model_resolve();
endtask

task automatic model_tick();
    int idx;
    if (m_game_over)
        return;
    // Ride first, with the log seen before it moves
    idx = log_under(m_frog);
    if (idx >= 0)
        m_frog.x = coord_t'(clamp_col(int'(m_frog.x) + dir_delta(m_logs[idx].dir)));
    for (int i = 0; i < NUM_CARS; i++)
        m_cars[i].pos.x = coord_t'(wrap_col(int'(m_cars[i].pos.x) + dir_delta(m_cars[i].dir)));
    for (int i = 0; i < NUM_LOGS; i++)
        m_logs[i].pos.x = coord_t'(wrap_col(int'(m_logs[i].pos.x) + dir_delta(m_logs[i].dir)));
    model_resolve();
endtask

`endif

/* verification/frogger_game_tb.sv */
`default_nettype none

module frogger_game_tb
    import frogger_geom_pkg::*;
    import frogger_game_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int SEED             = 14686;
    localparam int CLK_HALF         = 2;
    localparam int DRIVE_DELAY      = 1;
    localparam int RESET_CYCLES     = 8;
    localparam int NUM_EVENTS       = 2000;
    localparam int CYCLES_PER_EVENT = 6;
    localparam int TIMEOUT_CYCLES   = NUM_EVENTS * CYCLES_PER_EVENT + RESET_CYCLES;
    // Events run against a finished game before a fresh reset
    localparam int FROZEN_EVENTS    = 8;

    localparam int EV_MOVE = 0;
    localparam int EV_TICK = 1;
    localparam int EV_IDLE = 2;

    logic                i_Clk;
    logic                i_arst_n;
    logic                i_move_valid;
    move_t               i_move;
    logic                i_tick;
    logic                o_move_ready;
    pos_t                o_frog;
    car_t [NUM_CARS-1:0] o_cars;
    log_t [NUM_LOGS-1:0] o_logs;
    status_t             o_status;

    int cycle_count    = 0;
    int mismatch_count = 0;
    int other_errors   = 0;
    int frozen_count   = 0;

    `include "frogger_game_model.svh"

    frogger_game i_frogger_game (
        .i_Clk        (i_Clk),
        .i_arst_n     (i_arst_n),
        .i_move_valid (i_move_valid),
        .i_move       (i_move),
        .o_move_ready (o_move_ready),
        .i_tick       (i_tick),
        .o_frog       (o_frog),
        .o_cars       (o_cars),
        .o_logs       (o_logs),
        .o_status     (o_status)
    );

    initial
    begin
        i_Clk = 1'b0;
    end

    always #CLK_HALF i_Clk = ~i_Clk;

    // Hard stop on a hung handshake
    always @(posedge i_Clk)
    begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("Timeout: run did not end within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    // All outputs against the model at the falling edge
    task automatic compare_outputs(input logic exp_ready);
        assert (o_frog == m_frog)
        else
        begin
            mismatch_count++;
            $display("Mismatch o_frog at %0t: dut %h model %h", $time, o_frog, m_frog);
        end
        assert (o_cars == m_cars)
        else
        begin
            mismatch_count++;
            $display("Mismatch o_cars at %0t: dut %h model %h", $time, o_cars, m_cars);
        end
        assert (o_logs == m_logs)
        else
        begin
            mismatch_count++;
            $display("Mismatch o_logs at %0t: dut %h model %h", $time, o_logs, m_logs);
        end
        assert (o_status == model_status())
        else
        begin
            mismatch_count++;
            $display("Mismatch o_status at %0t: dut %h model %h", $time, o_status,
                     model_status());
        end
        assert (o_move_ready == exp_ready)
        else
        begin
            mismatch_count++;
            $display("Mismatch o_move_ready at %0t: dut %h model %h", $time, o_move_ready,
                     exp_ready);
        end
    endtask

    task automatic apply_reset();
        @(posedge i_Clk);
        #DRIVE_DELAY;
        i_arst_n     = 1'b0;
        i_move_valid = 1'b0;
        i_tick       = 1'b0;
        repeat (RESET_CYCLES) @(posedge i_Clk);
        #DRIVE_DELAY;
        i_arst_n = 1'b1;
        model_reset();
        @(negedge i_Clk);
        compare_outputs(1'b1);
    endtask

    // Poll at the falling edge until the core is idle
    task automatic wait_ready();
        while (!o_move_ready)
            @(negedge i_Clk);
    endtask

    // One event plus extra ticks on the busy cycles when inject is 1 or 2
    task automatic run_event(input int kind, input move_t mv, input int inject);
        logic was_over;
        logic busy_ready;
        was_over   = m_game_over;
        // Only an idle slot in a live game leaves ready high
        busy_ready = (kind == EV_IDLE) && !was_over;
        @(posedge i_Clk);
        #DRIVE_DELAY;
        if (kind == EV_MOVE)
        begin
            i_move_valid = 1'b1;
            i_move       = mv;
        end
        else if (kind == EV_TICK)
        begin
            i_tick = 1'b1;
        end
        @(negedge i_Clk);
        if ((kind == EV_MOVE) && !was_over)
        begin
            assert (o_move_ready)
            else
            begin
                other_errors++;
                $display("Idle core refused a move at %0t", $time);
            end
        end
        // Cycle 0 edge has passed
        @(posedge i_Clk);
        #DRIVE_DELAY;
        i_move_valid = 1'b0;
        i_tick       = 1'b0;
        if (kind == EV_MOVE)
            model_move(mv);
        else if (kind == EV_TICK)
            model_tick();
        // Busy cycles 1 to 3 where two ticks merge into one
        for (int c = 0; c < 3; c++)
        begin
            i_tick = (c < inject);
            @(negedge i_Clk);
            assert (o_move_ready == busy_ready)
            else
            begin
                mismatch_count++;
                $display("Mismatch o_move_ready at %0t: dut %h model %h", $time,
                         o_move_ready, busy_ready);
            end
            @(posedge i_Clk);
            #DRIVE_DELAY;
        end
        i_tick = 1'b0;
        @(negedge i_Clk);
        compare_outputs(!m_game_over && (inject == 0));
        // Held tick steps on the first idle edge
        if ((inject > 0) && !m_game_over)
        begin
            model_tick();
            repeat (4) @(posedge i_Clk);
            @(negedge i_Clk);
            compare_outputs(!m_game_over);
        end
    endtask

    initial
    begin
        int    seed;
        int    seed_ret;
        int    pick;
        int    kind;
        int    inject;
        move_t mv;
        i_arst_n     = 1'b0;
        i_move_valid = 1'b0;
        i_move       = MOVE_UP;
        i_tick       = 1'b0;
        seed         = SEED;
        seed_ret     = $urandom(seed);
        apply_reset();
        for (int ev = 0; ev < NUM_EVENTS; ev++)
        begin
            if (m_game_over && (frozen_count >= FROZEN_EVENTS))
            begin
                // New game
                frozen_count = 0;
                apply_reset();
            end
            else
            begin
                if (m_game_over)
                    frozen_count++;
                else
                    wait_ready();
                pick = $urandom % 100;
                if (pick < 60)
                    kind = EV_MOVE;
                else if (pick < 85)
                    kind = EV_TICK;
                else
                    kind = EV_IDLE;
                // UP weighted toward the goal row
                pick = $urandom % 10;
                if (pick < 4)
                    mv = MOVE_UP;
                else if (pick < 6)
                    mv = MOVE_DOWN;
                else if (pick < 8)
                    mv = MOVE_LEFT;
                else
                    mv = MOVE_RIGHT;
                inject = 0;
                if (!m_game_over && (kind != EV_IDLE) && (($urandom % 8) == 0))
                    inject = 1 + ($urandom % 2);
                run_event(kind, mv, inject);
            end
        end
        $display("Summary: %0d mismatches, %0d other errors over %0d events",
                 mismatch_count, other_errors, NUM_EVENTS);
        if ((mismatch_count == 0) && (other_errors == 0))
        begin
            $display("Simulation finished: PASS");
        end
        else
        begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* frogger_game.f */
+incdir+verification
source/frogger_geom_pkg.sv
source/frogger_game_pkg.sv
source/frogger_obstacle_lane.sv
source/frogger_collisions.sv
source/frogger_frog_control.sv
source/frogger_game.sv
verification/frogger_game_tb.sv
